// ==== filelist.f ====
+incdir+src
src/alu_pkg.sv
src/insn_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/alu_core.sv
testbench/tb_alu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module tb_alu_core

output=$(./obj_dir/Vtb_alu_core)
echo "$output"

if grep -qx "Regression passed" <<< "$output"; then
  exit 0
fi
exit 1

// ==== src/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// instruction word width
`define INSN_W 40

// register and result width
`define DATA_W 64

// architectural register count and index width
`define NREGS 16
`define REG_AW 4

// immediate field, sign-extended to DATA_W
`define IMM_W 20

// low bits of operand b used as shift amount
`define SHAMT_W 6

`endif

// ==== src/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_core import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               insn_valid,
  input  logic [`INSN_W-1:0] insn,
  output logic               retire_valid,
  output logic [`REG_AW-1:0] retire_rd,
  output logic [`DATA_W-1:0] retire_value,
  output flags_t             retire_flags,
  output logic               retire_taken,
  output logic               retire_illegal
);

  // decode to execute
  logic               dec_valid;
  op_e                dec_op;
  cond_e              dec_cond;
  logic [`REG_AW-1:0] dec_rd;
  logic [`REG_AW-1:0] dec_ra;
  logic [`REG_AW-1:0] dec_rb;
  logic [`DATA_W-1:0] dec_imm;
  logic               dec_illegal;

  // execute to result
  logic               ex_valid;
  logic [`REG_AW-1:0] ex_rd;
  logic [`DATA_W-1:0] ex_value;
  flags_t             ex_flags;
  logic               ex_wen;
  logic               ex_taken;
  logic               ex_illegal;

  // register file read path
  logic [`REG_AW-1:0] rd_addr_a;
  logic [`REG_AW-1:0] rd_addr_b;
  logic [`DATA_W-1:0] rf_data_a;
  logic [`DATA_W-1:0] rf_data_b;
  flags_t             cur_flags;

  insn_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .insn_valid  (insn_valid),
    .insn        (insn),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_cond    (dec_cond),
    .dec_rd      (dec_rd),
    .dec_ra      (dec_ra),
    .dec_rb      (dec_rb),
    .dec_imm     (dec_imm),
    .dec_illegal (dec_illegal)
  );

  alu_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_cond    (dec_cond),
    .dec_rd      (dec_rd),
    .dec_ra      (dec_ra),
    .dec_rb      (dec_rb),
    .dec_imm     (dec_imm),
    .dec_illegal (dec_illegal),
    .rf_data_a   (rf_data_a),
    .rf_data_b   (rf_data_b),
    .cur_flags   (cur_flags),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .ex_valid    (ex_valid),
    .ex_rd       (ex_rd),
    .ex_value    (ex_value),
    .ex_flags    (ex_flags),
    .ex_wen      (ex_wen),
    .ex_taken    (ex_taken),
    .ex_illegal  (ex_illegal)
  );

  result_writeback u_writeback (
    .clk            (clk),
    .rst            (rst),
    .rd_addr_a      (rd_addr_a),
    .rd_addr_b      (rd_addr_b),
    .ex_valid       (ex_valid),
    .ex_rd          (ex_rd),
    .ex_value       (ex_value),
    .ex_flags       (ex_flags),
    .ex_wen         (ex_wen),
    .ex_taken       (ex_taken),
    .ex_illegal     (ex_illegal),
    .rf_data_a      (rf_data_a),
    .rf_data_b      (rf_data_b),
    .cur_flags      (cur_flags),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_value   (retire_value),
    .retire_flags   (retire_flags),
    .retire_taken   (retire_taken),
    .retire_illegal (retire_illegal)
  );

endmodule

`default_nettype wire

// ==== src/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_execute import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               dec_valid,
  input  op_e                dec_op,
  input  cond_e              dec_cond,
  input  logic [`REG_AW-1:0] dec_rd,
  input  logic [`REG_AW-1:0] dec_ra,
  input  logic [`REG_AW-1:0] dec_rb,
  input  logic [`DATA_W-1:0] dec_imm,
  input  logic               dec_illegal,
  input  logic [`DATA_W-1:0] rf_data_a,
  input  logic [`DATA_W-1:0] rf_data_b,
  input  flags_t             cur_flags,
  output logic [`REG_AW-1:0] rd_addr_a,
  output logic [`REG_AW-1:0] rd_addr_b,
  output logic               ex_valid,
  output logic [`REG_AW-1:0] ex_rd,
  output logic [`DATA_W-1:0] ex_value,
  output flags_t             ex_flags,
  output logic               ex_wen,
  output logic               ex_taken,
  output logic               ex_illegal
);

  logic [`DATA_W-1:0]  op_a;
  logic [`DATA_W-1:0]  op_b;
  logic [`DATA_W-1:0]  add_b;
  logic [`DATA_W-1:0]  add_b_eff;
  logic [`DATA_W:0]    add_sum;
  logic                is_sub;
  logic                add_ovf;
  logic                arith;
  logic [`SHAMT_W-1:0] shamt;
  logic [`DATA_W-1:0]  result;
  flags_t              flags_in;
  flags_t              new_flags;
  flags_t              next_flags;
  logic                taken;
  logic                wen;

  function automatic logic cond_true(input cond_e cond, input flags_t fl);
    logic r;
    case (cond)
      EQ: r = fl.z;
      NE: r = ~fl.z;
      CS: r = fl.c;
      CC: r = ~fl.c;
      MI: r = fl.n;
      PL: r = ~fl.n;
      VS: r = fl.v;
      VC: r = ~fl.v;
      HI: r = fl.c & ~fl.z;
      LS: r = ~fl.c | fl.z;
      GE: r = (fl.n == fl.v);
      AL: r = 1'b1;
      LT: r = (fl.n != fl.v);
      GT: r = ~fl.z & (fl.n == fl.v);
      LE: r = fl.z | (fl.n != fl.v);
      default: r = 1'b0;
    endcase
    return r;
  endfunction

  assign rd_addr_a = dec_ra;
  assign rd_addr_b = dec_rb;

  // one-apart bypass from the ex registers
  assign op_a     = (ex_wen && ex_rd == dec_ra) ? ex_value : rf_data_a;
  assign op_b     = (ex_wen && ex_rd == dec_rb) ? ex_value : rf_data_b;
  assign flags_in = ex_taken ? ex_flags : cur_flags;

  assign taken = dec_valid & cond_true(dec_cond, flags_in);
  assign wen   = taken & (dec_op != OP_NOP);

  // shared adder, subtract as a + ~b + 1 so carry means no borrow
  assign is_sub    = (dec_op == OP_SUB);
  assign add_b     = (dec_op == OP_ADDI) ? dec_imm : op_b;
  assign add_b_eff = is_sub ? ~add_b : add_b;
  assign add_sum   = {1'b0, op_a} + {1'b0, add_b_eff} + {{`DATA_W{1'b0}}, is_sub};
  assign add_ovf   = (op_a[`DATA_W-1] == add_b_eff[`DATA_W-1]) &&
                     (add_sum[`DATA_W-1] != op_a[`DATA_W-1]);

  assign shamt = op_b[`SHAMT_W-1:0];

  always_comb begin
    result = add_sum[`DATA_W-1:0];
    arith  = 1'b0;
    case (dec_op)
      OP_ADD, OP_SUB, OP_ADDI: arith = 1'b1;
      OP_MOVI: result = dec_imm;
      OP_AND:  result = op_a & op_b;
      OP_XOR:  result = op_a ^ op_b;
      OP_OR:   result = op_a | op_b;
      OP_SHL:  result = op_a << shamt;
      OP_SHR:  result = op_a >> shamt;
      OP_SAR:  result = $signed(op_a) >>> shamt;
      default: result = op_a;
    endcase
  end

  assign new_flags.c = arith & add_sum[`DATA_W];
  assign new_flags.v = arith & add_ovf;
  assign new_flags.n = result[`DATA_W-1];
  assign new_flags.z = ~|result;

  // non-writing instructions carry the old flags forward
  assign next_flags = wen ? new_flags : flags_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
      ex_wen   <= 1'b0;
      ex_taken <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
      ex_wen   <= wen;
      ex_taken <= taken;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd      <= dec_rd;
    ex_value   <= result;
    ex_flags   <= next_flags;
    ex_illegal <= dec_illegal;
  end

endmodule

`default_nettype wire

// ==== src/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_ADDI = 4'd2,
    OP_MOVI = 4'd3,
    OP_AND  = 4'd4,
    OP_XOR  = 4'd5,
    OP_OR   = 4'd6,
    OP_SHL  = 4'd7,
    OP_SHR  = 4'd8,
    OP_SAR  = 4'd9,
    OP_NOP  = 4'd10
  } op_e;

  // flag-based condition codes
  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    AL = 4'd11,
    LT = 4'd12,
    GT = 4'd13,
    LE = 4'd14,
    NV = 4'd15
  } cond_e;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

endpackage

`default_nettype wire

// ==== src/insn_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module insn_decode import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               insn_valid,
  input  logic [`INSN_W-1:0] insn,
  output logic               dec_valid,
  output op_e                dec_op,
  output cond_e              dec_cond,
  output logic [`REG_AW-1:0] dec_rd,
  output logic [`REG_AW-1:0] dec_ra,
  output logic [`REG_AW-1:0] dec_rb,
  output logic [`DATA_W-1:0] dec_imm,
  output logic               dec_illegal
);

  // field positions, top down from the opcode
  localparam int OP_LSB   = `INSN_W - 4;
  localparam int COND_LSB = OP_LSB - 4;
  localparam int RD_LSB   = COND_LSB - `REG_AW;
  localparam int RA_LSB   = RD_LSB - `REG_AW;
  localparam int RB_LSB   = RA_LSB - `REG_AW;

  logic [3:0]         raw_op;
  logic               illegal;
  logic [`DATA_W-1:0] imm_ext;

  assign raw_op  = insn[OP_LSB +: 4];
  assign illegal = (raw_op > OP_NOP);
  assign imm_ext = {{(`DATA_W - `IMM_W){insn[`IMM_W-1]}}, insn[`IMM_W-1:0]};

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    dec_rd      <= insn[RD_LSB +: `REG_AW];
    dec_ra      <= insn[RA_LSB +: `REG_AW];
    dec_rb      <= insn[RB_LSB +: `REG_AW];
    dec_imm     <= imm_ext;
    dec_illegal <= illegal;
    // illegal opcodes never execute
    if (illegal) begin
      dec_op   <= OP_NOP;
      dec_cond <= NV;
    end else begin
      dec_op   <= op_e'(raw_op);
      dec_cond <= cond_e'(insn[COND_LSB +: 4]);
    end
  end

endmodule

`default_nettype wire

// ==== src/result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module result_writeback import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] rd_addr_a,
  input  logic [`REG_AW-1:0] rd_addr_b,
  input  logic               ex_valid,
  input  logic [`REG_AW-1:0] ex_rd,
  input  logic [`DATA_W-1:0] ex_value,
  input  flags_t             ex_flags,
  input  logic               ex_wen,
  input  logic               ex_taken,
  input  logic               ex_illegal,
  output logic [`DATA_W-1:0] rf_data_a,
  output logic [`DATA_W-1:0] rf_data_b,
  output flags_t             cur_flags,
  output logic               retire_valid,
  output logic [`REG_AW-1:0] retire_rd,
  output logic [`DATA_W-1:0] retire_value,
  output flags_t             retire_flags,
  output logic               retire_taken,
  output logic               retire_illegal
);

  logic [`DATA_W-1:0] rf [`NREGS];
  flags_t             flags_q;

  assign rf_data_a = rf[rd_addr_a];
  assign rf_data_b = rf[rd_addr_b];
  assign cur_flags = flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) begin
        rf[i] <= '0;
      end
      flags_q <= '0;
    end else if (ex_wen) begin
      rf[ex_rd] <= ex_value;
      flags_q   <= ex_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
    end
  end

  // skipped instructions report rd and flags as they stand
  always_ff @(posedge clk) begin
    retire_rd      <= ex_rd;
    retire_value   <= ex_wen ? ex_value : rf[ex_rd];
    retire_flags   <= ex_wen ? ex_flags : flags_q;
    retire_taken   <= ex_taken;
    retire_illegal <= ex_illegal;
  end

endmodule

`default_nettype wire

// ==== testbench/golden_vectors.txt ====
# columns: test insn rd value flags taken illegal (all but test in hex)
# insn is op cond rd ra rb imm20, flags nibble is c v n z
1 0B31200000 3 0000000000000000 1 1 0
2 3B10000005 1 0000000000000005 0 1 0
2 3B200FFFFF 2 FFFFFFFFFFFFFFFF 2 1 0
2 2B3107FFFF 3 0000000000080004 0 1 0
2 0B41200000 4 0000000000000004 8 1 0
2 3B60000001 6 0000000000000001 0 1 0
2 8B52600000 5 7FFFFFFFFFFFFFFF 0 1 0
2 0B75600000 7 8000000000000000 6 1 0
2 1B81600000 8 0000000000000004 8 1 0
2 1B96100000 9 FFFFFFFFFFFFFFFC 2 1 0
2 1BA1100000 A 0000000000000000 9 1 0
2 2BB10FFFFA B FFFFFFFFFFFFFFFF 2 1 0
3 4BC2100000 C 0000000000000005 0 1 0
3 5BC2200000 C 0000000000000000 1 1 0
3 6BD7600000 D 8000000000000001 2 1 0
3 7BD1100000 D 00000000000000A0 0 1 0
3 7BE6900000 E 1000000000000000 0 1 0
3 7BE7600000 E 0000000000000000 1 1 0
3 8BF7100000 F 0400000000000000 0 1 0
3 9BF7100000 F FC00000000000000 2 1 0
3 9BF9900000 F FFFFFFFFFFFFFFFF 2 1 0
3 9BC5600000 C 3FFFFFFFFFFFFFFF 0 1 0
4 3B10000010 1 0000000000000010 0 1 0
4 0B21100000 2 0000000000000020 0 1 0
4 0B32100000 3 0000000000000030 0 1 0
4 1B33200000 3 0000000000000010 8 1 0
4 2B33000001 3 0000000000000011 0 1 0
4 5B43100000 4 0000000000000001 0 1 0
4 7B44400000 4 0000000000000002 0 1 0
4 6B54300000 5 0000000000000013 0 1 0
4 1B61100000 6 0000000000000000 9 1 0
4 2070000007 7 0000000000000007 0 1 0
4 3180000008 8 0000000000000008 0 1 0
5 1B61200000 6 FFFFFFFFFFFFFFF0 2 1 0
5 3070000055 7 0000000000000007 2 0 0
5 3280000066 8 0000000000000008 2 0 0
5 0491100000 9 0000000000000020 0 1 0
5 2CAA000003 A 0000000000000000 0 0 0
5 0BBA900000 B 0000000000000020 0 1 0
5 3FB0000099 B 0000000000000020 0 0 0
5 1AC1100000 C 0000000000000000 9 1 0
5 38D0000001 D 00000000000000A0 9 0 0
5 39D0000002 D 0000000000000002 0 1 0
5 2DED000001 E 0000000000000003 0 1 0
5 36E0000077 E 0000000000000003 0 0 0
5 0BF7800000 F 000000000000000F 0 1 0
6 1B31200000 3 FFFFFFFFFFFFFFF0 2 1 0
6 BB10000123 1 0000000000000010 2 0 1
6 F030000000 3 FFFFFFFFFFFFFFF0 2 0 1
6 CB44400000 4 0000000000000002 2 0 1
6 0451300000 5 0000000000000000 9 1 0
6 AB60000000 6 FFFFFFFFFFFFFFF0 9 1 0
6 DB50000000 5 0000000000000000 9 0 1

// ==== testbench/tb_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_core;

  localparam int MAX_VEC = 64;

  logic               clk;
  logic               rst;
  logic               insn_valid;
  logic [`INSN_W-1:0] insn;
  logic               retire_valid;
  logic [`REG_AW-1:0] retire_rd;
  logic [`DATA_W-1:0] retire_value;
  logic [3:0]         retire_flags;
  logic               retire_taken;
  logic               retire_illegal;

  // golden vectors, one entry per instruction
  int                 vec_test    [MAX_VEC];
  logic [`INSN_W-1:0] vec_insn    [MAX_VEC];
  logic [`REG_AW-1:0] vec_rd      [MAX_VEC];
  logic [`DATA_W-1:0] vec_value   [MAX_VEC];
  logic [3:0]         vec_flags   [MAX_VEC];
  logic               vec_taken   [MAX_VEC];
  logic               vec_illegal [MAX_VEC];
  logic               vec_last    [MAX_VEC];
  int                 vec_sample  [MAX_VEC];
  int                 nvec;

  // indices of instructions in flight, oldest first
  int exp_q[$];

  int   cycle;
  int   cycle_limit;
  int   fail_count;
  int   tests_pass;
  int   tests_fail;
  logic test_bad;

  alu_core dut0 (
    .clk            (clk),
    .rst            (rst),
    .insn_valid     (insn_valid),
    .insn           (insn),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_value   (retire_value),
    .retire_flags   (retire_flags),
    .retire_taken   (retire_taken),
    .retire_illegal (retire_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      fail_count++;
      test_bad = 1'b1;
    end
  endtask

  task automatic load_vectors();
    int                 fd;
    int                 n;
    int                 t;
    string              line;
    logic [`INSN_W-1:0] w;
    logic [`REG_AW-1:0] r;
    logic [`DATA_W-1:0] v;
    logic [3:0]         f;
    logic               tk;
    logic               il;
    nvec = 0;
    fd = $fopen("testbench/golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/golden_vectors.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %h %h %h %h %h %h", t, w, r, v, f, tk, il);
        if (n == 7 && nvec < MAX_VEC) begin
          vec_test[nvec]    = t;
          vec_insn[nvec]    = w;
          vec_rd[nvec]      = r;
          vec_value[nvec]   = v;
          vec_flags[nvec]   = f;
          vec_taken[nvec]   = tk;
          vec_illegal[nvec] = il;
          nvec++;
        end
      end
      $fclose(fd);
    end
    // mark the last vector of each test
    for (int i = 0; i < nvec; i++) begin
      vec_last[i] = (i == nvec - 1) || (vec_test[i + 1] != vec_test[i]);
    end
  endtask

  task automatic drive_vectors();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < nvec; i++) begin
      @(posedge clk);
      #1;
      insn_valid = 1'b1;
      insn = vec_insn[i];
      // cycle count at issue, the dut samples on the next edge
      vec_sample[i] = cycle;
      exp_q.push_back(i);
    end
    @(posedge clk);
    #1;
    insn_valid = 1'b0;
    insn = '0;
    // three edges of latency plus a little slack
    repeat (5) @(posedge clk);
  endtask

  task automatic finish_report();
    if (exp_q.size() != 0) begin
      $display("Error: %0d instructions were issued but never retired", exp_q.size());
      fail_count++;
    end
    $display("tests passed %0d, tests failed %0d, errors %0d",
             tests_pass, tests_fail, fail_count);
    if (fail_count == 0 && tests_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // compare each retire against the oldest issued vector
  always @(negedge clk) begin
    int idx;
    if (retire_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Error at time %0t: retire with no instruction outstanding", $time);
        fail_count++;
      end else begin
        idx = exp_q.pop_front();
        check_value("retire_rd", 64'(vec_rd[idx]), 64'(retire_rd));
        check_value("retire_value", vec_value[idx], retire_value);
        check_value("retire_flags", 64'(vec_flags[idx]), 64'(retire_flags));
        check_value("retire_taken", 64'(vec_taken[idx]), 64'(retire_taken));
        check_value("retire_illegal", 64'(vec_illegal[idx]), 64'(retire_illegal));
        check_value("retire latency", 64'(vec_sample[idx] + 3), 64'(cycle));
        if (vec_last[idx]) begin
          if (test_bad) begin
            $display("test %0d: fail", vec_test[idx]);
            tests_fail++;
          end else begin
            $display("test %0d: pass", vec_test[idx]);
            tests_pass++;
          end
          test_bad = 1'b0;
        end
      end
    end
  end

  initial begin
    @(posedge clk);
    while (cycle <= cycle_limit) @(posedge clk);
    #1;
    $display("Timeout: run went past %0d cycles, %0d retires outstanding",
             cycle_limit, exp_q.size());
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    cycle = 0;
    fail_count = 0;
    tests_pass = 0;
    tests_fail = 0;
    test_bad = 1'b0;
    load_vectors();
    cycle_limit = nvec + 5 + 20;
    if (nvec == 0) begin
      $display("Error: no vectors loaded from the golden file");
      fail_count++;
    end else begin
      drive_vectors();
    end
    finish_report();
  end

endmodule

`default_nettype wire
